/* cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath and address width
`define CPU_XLEN        32
`define CPU_REG_ADDR_W  5

// Data RAM, word addressed
`define CPU_RAM_WORDS   256
`define CPU_RAM_ADDR_W  8

`define CPU_RESET_PC    32'h0000_0000

// ADDI x0, x0, 0
`define CPU_NOP         32'h0000_0013

`endif

/* cpu_pkg.sv */
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        BR_NONE, BR_EQ, BR_NE
    } branch_t;

    // All zero is a bubble: no write, no memory access, no branch
    typedef struct packed {
        logic                       reg_write;
        logic [`CPU_REG_ADDR_W-1:0] rd;
        logic                       mem_read;
        logic                       mem_write;
        logic                       mem_to_reg;
        alu_op_t                    alu_op;
        logic                       alu_src_imm;  // Operand B from immediate
        branch_t                    branch;
    } ctrl_t;

endpackage

`default_nettype wire

/* cpu_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

// Two combinational read ports of the register bank
interface rb_read_if;
    logic [`CPU_REG_ADDR_W-1:0] rs1;
    logic [`CPU_REG_ADDR_W-1:0] rs2;
    logic [`CPU_XLEN-1:0]       value1;
    logic [`CPU_XLEN-1:0]       value2;

    modport stage (output rs1, rs2, input value1, value2);
    modport bank (input rs1, rs2, output value1, value2);
endinterface

// Data RAM bus, read data one clock after the address
interface ram_if;
    logic [`CPU_XLEN-1:0] address;
    logic [`CPU_XLEN-1:0] write_data;
    logic                 write_enable;
    logic [`CPU_XLEN-1:0] read_data;

    modport master (output address, write_data, write_enable, input read_data);
    modport slave (input address, write_data, write_enable, output read_data);
endinterface

`default_nettype wire

/* register_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module register_bank (
    input  logic                       clock,
    input  logic                       rst_n,
    rb_read_if.bank                    bank,
    input  logic                       write_enable,
    input  logic [`CPU_REG_ADDR_W-1:0] write_address,
    input  logic [`CPU_XLEN-1:0]       write_value
);
    logic [`CPU_XLEN-1:0] regs [1:31];  // x0 has no storage

    // Write-through so a value retiring now is seen by decode
    function automatic logic [`CPU_XLEN-1:0] read_reg(input logic [`CPU_REG_ADDR_W-1:0] idx);
        if (idx == '0)
            return '0;
        else if (write_enable && write_address == idx)
            return write_value;
        else
            return regs[idx];
    endfunction

    assign bank.value1 = read_reg(bank.rs1);
    assign bank.value2 = read_reg(bank.rs2);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (write_enable && write_address != '0) begin
            regs[write_address] <= write_value;
        end
    end

endmodule

`default_nettype wire

/* ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module ram (
    input  logic  clock,
    ram_if.slave  bus
);
    logic [`CPU_XLEN-1:0] mem [`CPU_RAM_WORDS];
    logic [`CPU_RAM_ADDR_W-1:0] index;

    assign index = bus.address[`CPU_RAM_ADDR_W+1:2];  // Byte address to word index

    always_ff @(posedge clock) begin
        if (bus.write_enable)
            mem[index] <= bus.write_data;
        bus.read_data <= mem[index];  // Old word on a same-cycle write
    end

endmodule

`default_nettype wire

/* fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module fetch (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 enable,
    input  logic                 branch_taken,
    input  logic [`CPU_XLEN-1:0] branch_target,
    output logic [`CPU_XLEN-1:0] rom_address,
    input  logic [`CPU_XLEN-1:0] rom_data,
    output logic [`CPU_XLEN-1:0] pc,
    output logic [`CPU_XLEN-1:0] instr
);
    logic [`CPU_XLEN-1:0] pc_reg;

    assign rom_address = pc_reg;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc_reg <= `CPU_RESET_PC;
            instr  <= `CPU_NOP;
        end else if (enable) begin
            if (branch_taken) begin
                pc_reg <= branch_target;
                instr  <= `CPU_NOP;  // Drop the word fetched down the wrong path
            end else begin
                pc_reg <= pc_reg + 32'd4;
                instr  <= rom_data;
            end
        end
    end

    // IF/ID copy of the PC
    always_ff @(posedge clock) begin
        if (enable)
            pc <= pc_reg;
    end

endmodule

`default_nettype wire

/* decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module decode import cpu_pkg::*; (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       enable,
    input  logic [`CPU_XLEN-1:0]       pc_in,
    input  logic [`CPU_XLEN-1:0]       instr,
    input  logic                       flush,
    rb_read_if.stage                   rb,
    output ctrl_t                      ctrl,
    output logic [`CPU_XLEN-1:0]       imm,
    output logic [`CPU_XLEN-1:0]       rs1_value,
    output logic [`CPU_XLEN-1:0]       rs2_value,
    output logic [`CPU_REG_ADDR_W-1:0] rs1_idx,
    output logic [`CPU_REG_ADDR_W-1:0] rs2_idx,
    output logic [`CPU_XLEN-1:0]       pc_out
);
    opcode_t              opcode;
    logic [2:0]           funct3;
    ctrl_t                dec;
    logic [`CPU_XLEN-1:0] dec_imm;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rb.rs1 = instr[19:15];
    assign rb.rs2 = instr[24:20];

    always_comb begin
        dec     = '0;  // Unknown encodings fall through as a bubble
        dec_imm = '0;
        case (opcode)
            OP: begin
                dec.reg_write = 1'b1;
                dec.rd        = instr[11:7];
                case (funct3)
                    3'b000:  dec.alu_op = instr[30] ? ALU_SUB : ALU_ADD;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    default: dec = '0;
                endcase
            end
            OP_IMM: begin
                if (funct3 == 3'b000) begin  // ADDI only
                    dec.reg_write   = 1'b1;
                    dec.rd          = instr[11:7];
                    dec.alu_src_imm = 1'b1;
                end
                dec_imm = {{20{instr[31]}}, instr[31:20]};
            end
            LUI: begin
                dec.reg_write   = 1'b1;
                dec.rd          = instr[11:7];
                dec.alu_op      = ALU_PASS_B;
                dec.alu_src_imm = 1'b1;
                dec_imm         = {instr[31:12], 12'b0};
            end
            LOAD: begin
                dec.reg_write   = 1'b1;
                dec.rd          = instr[11:7];
                dec.mem_read    = 1'b1;
                dec.mem_to_reg  = 1'b1;
                dec.alu_src_imm = 1'b1;
                dec_imm         = {{20{instr[31]}}, instr[31:20]};
            end
            STORE: begin
                dec.mem_write   = 1'b1;
                dec.alu_src_imm = 1'b1;
                dec_imm         = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            BRANCH: begin
                if (funct3 == 3'b000)
                    dec.branch = BR_EQ;
                else if (funct3 == 3'b001)
                    dec.branch = BR_NE;
                dec_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            end
            default: ;
        endcase
    end

    // ID/EX control word
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            ctrl <= '0;
        else if (enable)
            ctrl <= flush ? ctrl_t'('0) : dec;
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            imm       <= dec_imm;
            rs1_value <= rb.value1;
            rs2_value <= rb.value2;
            rs1_idx   <= rb.rs1;
            rs2_idx   <= rb.rs2;
            pc_out    <= pc_in;
        end
    end

endmodule

`default_nettype wire

/* execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module execute import cpu_pkg::*; (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       enable,
    input  ctrl_t                      ctrl_in,
    input  logic [`CPU_XLEN-1:0]       imm,
    input  logic [`CPU_XLEN-1:0]       rs1_value,
    input  logic [`CPU_XLEN-1:0]       rs2_value,
    input  logic [`CPU_REG_ADDR_W-1:0] rs1_idx,
    input  logic [`CPU_REG_ADDR_W-1:0] rs2_idx,
    input  logic [`CPU_XLEN-1:0]       pc,
    input  logic                       wb_reg_write,
    input  logic [`CPU_REG_ADDR_W-1:0] wb_rd,
    input  logic [`CPU_XLEN-1:0]       wb_value,
    output ctrl_t                      ctrl_out,
    output logic [`CPU_XLEN-1:0]       result,
    output logic [`CPU_XLEN-1:0]       store_data,
    output logic                       branch_taken,
    output logic [`CPU_XLEN-1:0]       branch_target
);
    logic [`CPU_XLEN-1:0] op_a;
    logic [`CPU_XLEN-1:0] op_b_reg;
    logic [`CPU_XLEN-1:0] op_b;
    logic [`CPU_XLEN-1:0] alu_y;
    logic                 equal;
    logic                 taken_next;

    // Newest producer wins; x0 is never forwarded
    function automatic logic [`CPU_XLEN-1:0] forward(input logic [`CPU_REG_ADDR_W-1:0] idx,
                                                     input logic [`CPU_XLEN-1:0] reg_value);
        if (ctrl_out.reg_write && ctrl_out.rd != '0 && ctrl_out.rd == idx)
            return result;
        else if (wb_reg_write && wb_rd != '0 && wb_rd == idx)
            return wb_value;
        else
            return reg_value;
    endfunction

    assign op_a     = forward(rs1_idx, rs1_value);
    assign op_b_reg = forward(rs2_idx, rs2_value);
    assign op_b     = ctrl_in.alu_src_imm ? imm : op_b_reg;
    assign equal    = (op_a == op_b_reg);

    always_comb begin
        case (ctrl_in.alu_op)
            ALU_SUB:    alu_y = op_a - op_b;
            ALU_AND:    alu_y = op_a & op_b;
            ALU_OR:     alu_y = op_a | op_b;
            ALU_XOR:    alu_y = op_a ^ op_b;
            ALU_SLT:    alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_y = op_b;
            default:    alu_y = op_a + op_b;
        endcase
    end

    // The instruction behind a taken branch is already on the wrong path
    assign taken_next = !branch_taken &&
                        ((ctrl_in.branch == BR_EQ && equal) ||
                         (ctrl_in.branch == BR_NE && !equal));

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_out     <= '0;
            branch_taken <= 1'b0;
        end else if (enable) begin
            ctrl_out     <= branch_taken ? ctrl_t'('0) : ctrl_in;
            branch_taken <= taken_next;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            result        <= alu_y;
            store_data    <= op_b_reg;
            branch_target <= pc + imm;
        end
    end

endmodule

`default_nettype wire

/* memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module memory import cpu_pkg::*; (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 enable,
    input  ctrl_t                ctrl_in,
    input  logic [`CPU_XLEN-1:0] addr,
    input  logic [`CPU_XLEN-1:0] store_data,
    ram_if.master                bus,
    output ctrl_t                ctrl_out,
    output logic [`CPU_XLEN-1:0] alu_result,
    output logic [`CPU_XLEN-1:0] load_data
);
    ctrl_t mem_wb_ctrl;

    // While frozen the RAM keeps re-reading the word owned by MEM/WB
    assign bus.address      = enable ? addr : alu_result;
    assign bus.write_data   = store_data;
    assign bus.write_enable = ctrl_in.mem_write & enable;
    assign load_data        = bus.read_data;  // Lines up with MEM/WB

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            mem_wb_ctrl <= '0;
        else if (enable)
            mem_wb_ctrl <= ctrl_in;
    end

    always_ff @(posedge clock) begin
        if (enable)
            alu_result <= addr;
    end

    // No register write while the pipeline is held
    always_comb begin
        ctrl_out           = mem_wb_ctrl;
        ctrl_out.reg_write = mem_wb_ctrl.reg_write & enable;
    end

endmodule

`default_nettype wire

/* writeback.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module writeback import cpu_pkg::*; (
    input  ctrl_t                      ctrl,
    input  logic [`CPU_XLEN-1:0]       alu_result,
    input  logic [`CPU_XLEN-1:0]       load_data,
    output logic                       write_enable,
    output logic [`CPU_REG_ADDR_W-1:0] write_address,
    output logic [`CPU_XLEN-1:0]       write_value
);
    // x0 writes are dropped here so they never show on the trace
    assign write_enable  = ctrl.reg_write && ctrl.rd != '0;
    assign write_address = ctrl.rd;
    assign write_value   = ctrl.mem_to_reg ? load_data : alu_result;

endmodule

`default_nettype wire

/* cpu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu import cpu_pkg::*; (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       enable,
    input  logic [`CPU_XLEN-1:0]       rom_data,
    output logic [`CPU_XLEN-1:0]       rom_address,
    output logic [5:0]                 led,
    output logic                       retire_valid,
    output logic [`CPU_REG_ADDR_W-1:0] retire_rd,
    output logic [`CPU_XLEN-1:0]       retire_value
);
    rb_read_if rb_read ();
    ram_if     ram_bus ();

    // Fetch to decode
    logic [`CPU_XLEN-1:0] if_de_pc;
    logic [`CPU_XLEN-1:0] if_de_instr;

    // Decode to execute
    ctrl_t                      de_ex_ctrl;
    logic [`CPU_XLEN-1:0]       de_ex_imm;
    logic [`CPU_XLEN-1:0]       de_ex_value1;
    logic [`CPU_XLEN-1:0]       de_ex_value2;
    logic [`CPU_REG_ADDR_W-1:0] de_ex_rs1;
    logic [`CPU_REG_ADDR_W-1:0] de_ex_rs2;
    logic [`CPU_XLEN-1:0]       de_ex_pc;

    // Execute to memory, plus the redirect back to the front end
    ctrl_t                ex_mem_ctrl;
    logic [`CPU_XLEN-1:0] ex_mem_result;
    logic [`CPU_XLEN-1:0] ex_mem_store_data;
    logic                 branch_taken;
    logic [`CPU_XLEN-1:0] branch_target;

    // Memory to writeback
    ctrl_t                mem_wb_ctrl;
    logic [`CPU_XLEN-1:0] mem_wb_alu_result;
    logic [`CPU_XLEN-1:0] mem_wb_load_data;

    assign led = ex_mem_result[5:0];

    fetch u_fetch (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .rom_address(rom_address), .rom_data(rom_data),
        .pc(if_de_pc), .instr(if_de_instr)
    );

    decode u_decode (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .pc_in(if_de_pc), .instr(if_de_instr), .flush(branch_taken), .rb(rb_read),
        .ctrl(de_ex_ctrl), .imm(de_ex_imm),
        .rs1_value(de_ex_value1), .rs2_value(de_ex_value2),
        .rs1_idx(de_ex_rs1), .rs2_idx(de_ex_rs2), .pc_out(de_ex_pc)
    );

    execute u_execute (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .ctrl_in(de_ex_ctrl), .imm(de_ex_imm),
        .rs1_value(de_ex_value1), .rs2_value(de_ex_value2),
        .rs1_idx(de_ex_rs1), .rs2_idx(de_ex_rs2), .pc(de_ex_pc),
        .wb_reg_write(retire_valid), .wb_rd(retire_rd), .wb_value(retire_value),
        .ctrl_out(ex_mem_ctrl), .result(ex_mem_result), .store_data(ex_mem_store_data),
        .branch_taken(branch_taken), .branch_target(branch_target)
    );

    memory u_memory (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .ctrl_in(ex_mem_ctrl), .addr(ex_mem_result), .store_data(ex_mem_store_data),
        .bus(ram_bus),
        .ctrl_out(mem_wb_ctrl), .alu_result(mem_wb_alu_result), .load_data(mem_wb_load_data)
    );

    // The register-bank write port doubles as the retire trace
    writeback u_writeback (
        .ctrl(mem_wb_ctrl), .alu_result(mem_wb_alu_result), .load_data(mem_wb_load_data),
        .write_enable(retire_valid), .write_address(retire_rd), .write_value(retire_value)
    );

    register_bank u_register_bank (
        .clock(clock), .rst_n(rst_n), .bank(rb_read),
        .write_enable(retire_valid), .write_address(retire_rd), .write_value(retire_value)
    );

    ram u_ram (
        .clock(clock),
        .bus(ram_bus)
    );

endmodule

`default_nettype wire

/* tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
    localparam int TIMEOUT_CYCLES = 400;
    localparam logic [31:0] HALT = 32'h0000_0063;  // BEQ x0, x0, 0

    localparam int OP_ADD = 0;
    localparam int OP_SUB = 1;
    localparam int OP_AND = 2;
    localparam int OP_OR  = 3;
    localparam int OP_XOR = 4;
    localparam int OP_SLT = 5;

    logic        clock;
    logic        rst_n;
    logic        enable;
    logic [31:0] rom_data;
    logic [31:0] rom_address;
    logic [5:0]  led;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_value;

    logic [31:0] rom [64];
    int          prog_len = 0;
    logic [31:0] ref_regs [32];
    logic [31:0] ref_mem [256];   // Mirrors the data RAM across tests
    logic [31:0] ref_pc;
    logic [42:0] exp_q [$];       // {led, rd, value} in program order
    logic [42:0] exp_event;
    logic [5:0]  led_seen;
    integer      seed = 94489;
    int          retired_total = 0;
    int          retire_fails = 0;
    int          test_fails = 0;

    cpu uut (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .rom_data(rom_data), .rom_address(rom_address), .led(led),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_value(retire_value)
    );

    // Past the end of the program the ROM returns the halt loop
    assign rom_data = ({2'b00, rom_address[31:2]} < prog_len) ? rom[rom_address[7:2]] : HALT;

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, inout int fails);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            fails++;
        end
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [31:0] rom_word(input logic [31:0] addr);
        if ({2'b00, addr[31:2]} < prog_len)
            return rom[addr[7:2]];
        else
            return HALT;
    endfunction

    task automatic emit(input logic [31:0] word);
        rom[prog_len[5:0]] = word;
        prog_len++;
    endtask

    task automatic alu_rr(input int kind, input int rd, input int rs1, input int rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = (kind == OP_SUB) ? 7'b0100000 : 7'b0000000;
        case (kind)
            OP_AND:  f3 = 3'b111;
            OP_OR:   f3 = 3'b110;
            OP_XOR:  f3 = 3'b100;
            OP_SLT:  f3 = 3'b010;
            default: f3 = 3'b000;
        endcase
        emit({f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011});
    endtask

    task automatic addi(input int rd, input int rs1, input int imm);
        emit({imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011});
    endtask

    // Loads the upper 20 bits of value
    task automatic lui(input int rd, input int value);
        emit({value[31:12], rd[4:0], 7'b0110111});
    endtask

    task automatic lw(input int rd, input int base, input int off);
        emit({off[11:0], base[4:0], 3'b010, rd[4:0], 7'b0000011});
    endtask

    task automatic sw(input int src, input int base, input int off);
        emit({off[11:5], src[4:0], base[4:0], 3'b010, off[4:0], 7'b0100011});
    endtask

    task automatic branch(input logic ne, input int rs1, input int rs2, input int off);
        emit({off[12], off[10:5], rs2[4:0], rs1[4:0], 2'b00, ne, off[4:1], off[11],
              7'b1100011});
    endtask

    // Instruction-set model that runs until the next write to a nonzero register
    function automatic logic [43:0] reference_next_retire();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] next_pc;
        logic [4:0]  rd;
        logic        write;
        logic        load;
        logic        taken;
        int          n;
        for (n = 0; n < 1000; n++) begin
            ins     = rom_word(ref_pc);
            rd      = ins[11:7];
            a       = ref_regs[ins[19:15]];
            b       = ref_regs[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            next_pc = ref_pc + 32'd4;
            write   = 1'b0;
            load    = 1'b0;
            res     = 32'h0;
            case (ins[6:0])
                7'b0110011: begin
                    write = 1'b1;
                    case (ins[14:12])
                        3'b000:  res = ins[30] ? a - b : a + b;
                        3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                        3'b100:  res = a ^ b;
                        3'b110:  res = a | b;
                        default: res = a & b;
                    endcase
                end
                7'b0010011: begin
                    write = 1'b1;
                    res   = a + imm_i;
                end
                7'b0110111: begin
                    write = 1'b1;
                    res   = {ins[31:12], 12'b0};
                end
                7'b0000011: begin
                    write = 1'b1;
                    load  = 1'b1;
                    addr  = a + imm_i;
                    res   = ref_mem[addr[9:2]];
                end
                7'b0100011: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    ref_mem[addr[9:2]] = b;
                end
                7'b1100011: begin
                    taken = ins[12] ? (a != b) : (a == b);  // BNE : BEQ
                    if (taken) begin
                        next_pc = ref_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                            ins[11:8], 1'b0};
                        if (next_pc == ref_pc)
                            return 44'h0;  // Halt loop reached
                    end
                end
                default: ;
            endcase
            ref_pc = next_pc;
            if (write && rd != 5'd0) begin
                ref_regs[rd] = res;
                // The EX/MEM result of a load is its address
                return {1'b1, load ? addr[5:0] : res[5:0], rd, res};
            end
        end
        return 44'h0;
    endfunction

    // Compares every retire against the next reference event
    always @(negedge clock) begin
        if (rst_n && retire_valid) begin
            retired_total++;
            if (exp_q.size() == 0) begin
                $display("ERROR t=%0t: x%0d retired after the program had ended",
                         $time, retire_rd);
                retire_fails++;
            end else begin
                exp_event = exp_q.pop_front();
                check_value("retire_rd", {27'b0, exp_event[36:32]}, {27'b0, retire_rd},
                            retire_fails);
                check_value("retire_value", exp_event[31:0], retire_value, retire_fails);
                check_value("led", {26'b0, exp_event[42:37]}, {26'b0, led_seen},
                            retire_fails);
            end
        end
        // led belongs to the instruction retiring in the next enabled cycle
        if (rst_n && enable)
            led_seen = led;
    end

    task automatic hold_reset();
        rst_n    = 1'b0;
        enable   = 1'b1;
        prog_len = 0;
    endtask

    task automatic build_arith();
        logic [31:0] r;
        int          i;
        for (i = 1; i <= 6; i++) begin
            r = rand_word();
            lui(i, r);
            addi(i, i, r);
        end
        for (i = 0; i < 20; i++) begin
            r = rand_word();
            if ((r >> 9 & 7) < 6)
                alu_rr(r >> 9 & 7, r & 7, r >> 3 & 7, r >> 6 & 7);
            else if ((r >> 9 & 7) == 6)
                addi(r & 7, r >> 3 & 7, r >> 20);
            else
                lui(r & 7, r);
        end
    endtask

    task automatic build_forwarding();
        addi(1, 0, 5);
        addi(2, 1, 3);            // Distance 1
        alu_rr(OP_ADD, 3, 2, 1);  // Distances 1 and 2
        alu_rr(OP_ADD, 4, 1, 3);  // Distance 3 through the bank
        alu_rr(OP_SUB, 5, 4, 2);
        addi(6, 0, 7);
        addi(6, 6, 1);
        addi(6, 6, 1);
        alu_rr(OP_XOR, 7, 6, 6);
        addi(8, 0, 1);
        addi(8, 0, 2);            // Newer producer must win
        alu_rr(OP_ADD, 9, 8, 0);
        addi(0, 0, 9);
        alu_rr(OP_OR, 10, 0, 0);  // x0 stays zero
        alu_rr(OP_SLT, 11, 5, 1);
        alu_rr(OP_AND, 12, 11, 9);
    endtask

    task automatic build_memory();
        logic [31:0] r;
        r = rand_word();
        lui(2, r);
        addi(2, 2, r);
        r = rand_word();
        lui(3, r);
        addi(3, 3, r);
        addi(1, 0, 32'h40);
        sw(2, 1, 0);
        sw(3, 1, 4);
        addi(4, 1, 8);
        sw(3, 4, 0);              // Base forwarded from the line above
        lw(5, 1, 4);
        addi(6, 0, 1);
        lw(7, 1, 0);
        addi(8, 0, 2);
        alu_rr(OP_ADD, 9, 5, 7);  // Load data two behind
        lw(10, 4, 0);
        addi(11, 6, 3);
        alu_rr(OP_XOR, 12, 10, 2);
        sw(9, 1, 12);
        lw(13, 1, 12);            // Right behind the store
        addi(14, 0, 5);
        sw(13, 1, 16);
        lw(15, 1, 16);
        addi(16, 0, 6);
        lw(17, 4, -4);
        addi(18, 0, 7);
    endtask

    task automatic build_branches();
        addi(1, 0, 3);
        addi(2, 0, 3);
        addi(3, 0, 4);
        branch(1'b0, 1, 2, 12);   // Taken BEQ
        addi(4, 0, 1);
        addi(5, 0, 1);
        addi(6, 0, 6);
        branch(1'b1, 1, 2, 8);    // BNE not taken
        addi(7, 0, 7);
        branch(1'b1, 1, 3, 12);   // Taken BNE
        addi(8, 0, 8);
        addi(9, 0, 9);
        addi(10, 0, 10);
        branch(1'b0, 1, 3, 8);    // BEQ not taken
        addi(11, 0, 11);
        addi(12, 0, 3);
        addi(12, 12, -1);         // Loop body
        branch(1'b1, 12, 0, -4);
        addi(13, 0, 13);
    endtask

    task automatic run_program(input string name, input int stall_at, input int stall_len);
        int          fails_before;
        int          retired_before;
        int          total;
        int          cycles;
        logic [43:0] ev;
        fails_before   = test_fails + retire_fails;
        retired_before = retired_total;
        ref_regs       = '{default: 32'h0};
        ref_pc         = 32'h0;
        exp_q.delete();
        ev = reference_next_retire();
        while (ev[43] && exp_q.size() < 1000) begin
            exp_q.push_back(ev[42:0]);
            ev = reference_next_retire();
        end
        total = exp_q.size();
        repeat (5) next_cycle();
        check_value("rom_address", 32'h0, rom_address, test_fails);
        check_value("retire_valid", 32'h0, {31'b0, retire_valid}, test_fails);
        rst_n  = 1'b1;
        cycles = 0;
        while (retired_total - retired_before < total && cycles < TIMEOUT_CYCLES) begin
            if (stall_len > 0 && cycles == stall_at)
                enable = 1'b0;
            if (stall_len > 0 && cycles == stall_at + stall_len)
                enable = 1'b1;
            next_cycle();
            cycles++;
        end
        enable = 1'b1;
        if (retired_total - retired_before < total) begin
            $display("ERROR: %s timed out after %0d cycles with %0d of %0d instructions retired",
                     name, cycles, retired_total - retired_before, total);
            test_fails++;
        end else begin
            repeat (8) next_cycle();  // Any retire now is an extra one
        end
        $display("%s: %0d of %0d retires, %0d errors", name, retired_total - retired_before,
                 total, test_fails + retire_fails - fails_before);
    endtask

    initial begin
        rst_n  = 1'b0;
        enable = 1'b1;
        hold_reset();
        build_arith();
        run_program("arithmetic", 0, 0);
        hold_reset();
        build_forwarding();
        run_program("forwarding", 0, 0);
        hold_reset();
        build_memory();
        run_program("load_store", 0, 0);
        hold_reset();
        build_branches();
        run_program("branches", 0, 0);
        hold_reset();
        build_memory();
        run_program("enable_reset", 9, 6);  // Freeze mid-program
        $display("tests: 5, retires: %0d, errors: %0d", retired_total,
                 test_fails + retire_fails);
        if (test_fails + retire_fails == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
cpu_pkg.sv
cpu_if.sv
register_bank.sv
ram.sv
fetch.sv
decode.sv
execute.sv
memory.sv
writeback.sv
cpu.sv
tb_cpu.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -j 0 -Wno-fatal
TOP      = tb_cpu
FILELIST = build.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
